/* hw/alu_cmd_pkg.sv */
// ALU command package with command codes and the decoded datapath controls
`default_nettype none

package alu_cmd_pkg;

  localparam int CMD_BITS = 3;

  // Command encodings of the ALU lookup table
  typedef enum logic [CMD_BITS-1:0] {
    CMD_ADD  = 3'd0,
    CMD_SUB  = 3'd1,
    CMD_XOR  = 3'd2,
    CMD_SLT  = 3'd3,
    CMD_AND  = 3'd4,
    CMD_NAND = 3'd5,
    CMD_NOR  = 3'd6,
    CMD_OR   = 3'd7
  } alu_cmd_e;

  // Source of the result word
  typedef enum logic [1:0] {
    PATH_ARITH = 2'd0,
    PATH_LOGIC = 2'd1,
    PATH_SLT   = 2'd2
  } alu_path_e;

  // Bitwise operation where NAND and NOR come from invert_out
  typedef enum logic [1:0] {
    LOP_XOR = 2'd0,
    LOP_AND = 2'd1,
    LOP_OR  = 2'd2
  } logic_op_e;

  typedef struct packed {
    alu_path_e path;
    logic_op_e logic_op;
    logic      invert_b;
    logic      carry_in;
    logic      invert_out;
  } alu_ctrl_t;

  // Plain add control that is also loaded at reset
  localparam alu_ctrl_t CTRL_DEFAULT = '{
    path:       PATH_ARITH,
    logic_op:   LOP_XOR,
    invert_b:   1'b0,
    carry_in:   1'b0,
    invert_out: 1'b0
  };

endpackage

`default_nettype wire

/* hw/alu_data_pkg.sv */
// ALU data package with the word type, flags and the request and response records
`default_nettype none

package alu_data_pkg;

  import alu_cmd_pkg::*;

  localparam int WORD_BITS = 32;

  typedef logic [WORD_BITS-1:0] word_t;

  typedef struct packed {
    logic carry;
    logic overflow;
    logic zero;
  } alu_flags_t;

  // Held stable by the requester while req is high
  typedef struct packed {
    alu_cmd_e cmd;
    word_t    a;
    word_t    b;
  } alu_req_t;

  // Valid while ack is high
  typedef struct packed {
    word_t      result;
    alu_flags_t flags;
  } alu_rsp_t;

endpackage

`default_nettype wire

/* hw/alu_decode.sv */
// ALU decode stage that captures a request and registers operands and control
`timescale 1ns/100ps
`default_nettype none

module alu_decode import alu_cmd_pkg::*, alu_data_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      capture,
  input  alu_req_t  request,
  output word_t     a,
  output word_t     b,
  output alu_ctrl_t ctrl
);

  alu_ctrl_t decoded;

  // Command lookup table
  always_comb begin
    decoded = CTRL_DEFAULT;
    case (request.cmd)
      CMD_ADD: begin
        decoded.path = PATH_ARITH;
      end
      CMD_SUB: begin
        decoded.path     = PATH_ARITH;
        decoded.invert_b = 1'b1;
        decoded.carry_in = 1'b1;
      end
      CMD_XOR: begin
        decoded.path     = PATH_LOGIC;
        decoded.logic_op = LOP_XOR;
      end
      CMD_SLT: begin
        // a - b, the sign corrected by overflow gives the answer
        decoded.path     = PATH_SLT;
        decoded.invert_b = 1'b1;
        decoded.carry_in = 1'b1;
      end
      CMD_AND: begin
        decoded.path     = PATH_LOGIC;
        decoded.logic_op = LOP_AND;
      end
      CMD_NAND: begin
        decoded.path       = PATH_LOGIC;
        decoded.logic_op   = LOP_AND;
        decoded.invert_out = 1'b1;
      end
      CMD_NOR: begin
        decoded.path       = PATH_LOGIC;
        decoded.logic_op   = LOP_OR;
        decoded.invert_out = 1'b1;
      end
      CMD_OR: begin
        decoded.path     = PATH_LOGIC;
        decoded.logic_op = LOP_OR;
      end
      default: begin
        decoded = CTRL_DEFAULT;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl <= CTRL_DEFAULT;
    end else if (capture) begin
      ctrl <= decoded;
    end
  end

  // Operands held for the whole transaction
  always_ff @(posedge clk) begin
    if (capture) begin
      a <= request.a;
      b <= request.b;
    end
  end

endmodule

`default_nettype wire

/* hw/alu_execute.sv */
// ALU execute datapath with shared adder, bitwise unit and result select
`timescale 1ns/100ps
`default_nettype none

module alu_execute import alu_cmd_pkg::*, alu_data_pkg::*; (
  input  word_t     a,
  input  word_t     b,
  input  alu_ctrl_t ctrl,
  output word_t     result,
  output logic      carry,
  output logic      overflow
);

  word_t adder_b;
  word_t sum;
  logic  adder_carry;
  logic  adder_overflow;
  logic  less_than;
  logic  uses_adder;
  word_t bitwise;
  word_t logic_word;

  // Subtract is a + ~b + 1
  assign adder_b = ctrl.invert_b ? ~b : b;

  assign {adder_carry, sum} = {1'b0, a} + {1'b0, adder_b}
                            + {{WORD_BITS{1'b0}}, ctrl.carry_in};

  // Same sign operands into the adder but the sum sign flipped
  assign adder_overflow = (a[WORD_BITS-1] == adder_b[WORD_BITS-1])
                       && (sum[WORD_BITS-1] != a[WORD_BITS-1]);

  assign less_than = sum[WORD_BITS-1] ^ adder_overflow;

  always_comb begin
    case (ctrl.logic_op)
      LOP_XOR: begin
        bitwise = a ^ b;
      end
      LOP_AND: begin
        bitwise = a & b;
      end
      LOP_OR: begin
        bitwise = a | b;
      end
      default: begin
        bitwise = '0;
      end
    endcase
  end

  assign logic_word = ctrl.invert_out ? ~bitwise : bitwise;

  always_comb begin
    case (ctrl.path)
      PATH_ARITH: begin
        result = sum;
      end
      PATH_SLT: begin
        result = {{(WORD_BITS-1){1'b0}}, less_than};
      end
      PATH_LOGIC: begin
        result = logic_word;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // SLT keeps the flags of its subtraction, logic ops clear them
  assign uses_adder = (ctrl.path == PATH_ARITH) || (ctrl.path == PATH_SLT);
  assign carry      = uses_adder & adder_carry;
  assign overflow   = uses_adder & adder_overflow;

endmodule

`default_nettype wire

/* hw/alu_result.sv */
// ALU result stage with req/ack handshake FSM and the response register
`timescale 1ns/100ps
`default_nettype none

module alu_result import alu_data_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     req,
  output logic     ack,
  output logic     capture,
  input  word_t    result,
  input  logic     carry,
  input  logic     overflow,
  output alu_rsp_t response
);

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    HOLD,
    RELEASE
  } state_e;

  state_e state;
  state_e next_state;

  word_t result_reg;
  logic  carry_reg;
  logic  overflow_reg;
  logic  zero_flag;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (req) begin
          next_state = EXEC;
        end
      end
      EXEC: begin
        next_state = HOLD;
      end
      HOLD: begin
        // Requester keeps req high for as long as it needs the response
        if (!req) begin
          next_state = RELEASE;
        end
      end
      RELEASE: begin
        next_state = IDLE;
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Decode latches operands on the same edge the FSM leaves IDLE
  assign capture = (state == IDLE) && req;
  assign ack     = (state == HOLD);

  always_ff @(posedge clk) begin
    if (reset) begin
      result_reg   <= '0;
      carry_reg    <= 1'b0;
      overflow_reg <= 1'b0;
    end else if (state == EXEC) begin
      result_reg   <= result;
      carry_reg    <= carry;
      overflow_reg <= overflow;
    end
  end

  assign zero_flag = (result_reg == '0);

  assign response.result         = result_reg;
  assign response.flags.carry    = carry_reg;
  assign response.flags.overflow = overflow_reg;
  assign response.flags.zero     = zero_flag;

endmodule

`default_nettype wire

/* hw/alu_unit.sv */
// ALU unit top level joining decode, execute and result stages
`timescale 1ns/100ps
`default_nettype none

module alu_unit import alu_cmd_pkg::*, alu_data_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     req,
  input  alu_req_t request,
  output logic     ack,
  output alu_rsp_t response
);

  logic      capture;
  word_t     a_word;
  word_t     b_word;
  alu_ctrl_t ctrl;
  word_t     raw_result;
  logic      raw_carry;
  logic      raw_overflow;

  alu_decode i_alu_decode (
    .clk     (clk),
    .reset   (reset),
    .capture (capture),
    .request (request),
    .a       (a_word),
    .b       (b_word),
    .ctrl    (ctrl)
  );

  alu_execute i_alu_execute (
    .a        (a_word),
    .b        (b_word),
    .ctrl     (ctrl),
    .result   (raw_result),
    .carry    (raw_carry),
    .overflow (raw_overflow)
  );

  alu_result i_alu_result (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .ack      (ack),
    .capture  (capture),
    .result   (raw_result),
    .carry    (raw_carry),
    .overflow (raw_overflow),
    .response (response)
  );

endmodule

`default_nettype wire

/* verif/alu_unit_checker.sv */
// ALU unit handshake checker with concurrent assertions bound into the top level
`timescale 1ns/100ps
`default_nettype none

module alu_unit_checker import alu_data_pkg::*; (
  input logic     clk,
  input logic     reset,
  input logic     req,
  input logic     ack,
  input alu_rsp_t response
);

  int assert_errors = 0;

  ack_low_after_reset: assert property (@(posedge clk) reset |=> !ack)
    else begin
      assert_errors++;
      $error("ack high after reset");
    end

  // ack may only rise in answer to a request
  ack_rise_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req))
    else begin
      assert_errors++;
      $error("ack rose without req");
    end

  ack_fall_needs_release: assert property (@(posedge clk) disable iff (reset)
    $fell(ack) |-> !$past(req))
    else begin
      assert_errors++;
      $error("ack fell while req high");
    end

  response_held: assert property (@(posedge clk) disable iff (reset)
    ($past(ack) && ack) |-> $stable(response))
    else begin
      assert_errors++;
      $error("response changed while ack high");
    end

endmodule

bind alu_unit alu_unit_checker i_alu_unit_checker (
  .clk      (clk),
  .reset    (reset),
  .req      (req),
  .ack      (ack),
  .response (response)
);

`default_nettype wire

/* verif/alu_unit_tb.sv */
// ALU unit testbench driving a table of commands through the req/ack handshake
`timescale 1ns/100ps
`default_nettype none

module alu_unit_tb import alu_cmd_pkg::*, alu_data_pkg::*;;

  localparam int NUM_FIXED   = 24;
  localparam int NUM_RANDOM  = 20;
  localparam int NUM_ENTRIES = NUM_FIXED + NUM_RANDOM;

  typedef struct packed {
    alu_cmd_e   cmd;
    word_t      a;
    word_t      b;
    word_t      exp_result;
    alu_flags_t exp_flags;
  } vector_t;

  logic     clk;
  logic     reset;
  logic     req;
  alu_req_t request;
  logic     ack;
  alu_rsp_t response;

  vector_t     table_q[$];
  int          errors = 0;
  int unsigned rng_state = 40;

  alu_unit i_alu_unit (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .request  (request),
    .ack      (ack),
    .response (response)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int unsigned lcg_next(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic word_t random_word();
    logic [15:0] upper;
    rng_state = lcg_next(rng_state);
    upper = rng_state[31:16];
    rng_state = lcg_next(rng_state);
    return {upper, rng_state[31:16]};
  endfunction

  // True when a signed result does not fit in one word
  function automatic logic out_of_range(input longint value);
    return (value >= (64'sd1 <<< (WORD_BITS-1))) || (value < -(64'sd1 <<< (WORD_BITS-1)));
  endfunction

  // Reference model from signed arithmetic on wide integers and unsigned compares
  function automatic vector_t expect_entry(input alu_cmd_e cmd, input word_t a, input word_t b);
    vector_t v;
    longint  sa;
    longint  sb;
    v.cmd       = cmd;
    v.a         = a;
    v.b         = b;
    v.exp_flags = '0;
    sa          = $signed(a);
    sb          = $signed(b);
    case (cmd)
      CMD_ADD: begin
        // Unsigned sum wrapped past the top when it ends below a
        v.exp_result          = a + b;
        v.exp_flags.carry     = (v.exp_result < a);
        v.exp_flags.overflow  = out_of_range(sa + sb);
      end
      CMD_SUB: begin
        v.exp_result          = a - b;
        v.exp_flags.carry     = (a >= b);
        v.exp_flags.overflow  = out_of_range(sa - sb);
      end
      CMD_SLT: begin
        v.exp_result          = (sa < sb) ? word_t'(1) : '0;
        v.exp_flags.carry     = (a >= b);
        v.exp_flags.overflow  = out_of_range(sa - sb);
      end
      CMD_XOR:  v.exp_result = a ^ b;
      CMD_AND:  v.exp_result = a & b;
      CMD_NAND: v.exp_result = ~(a & b);
      CMD_NOR:  v.exp_result = ~(a | b);
      default:  v.exp_result = a | b;
    endcase
    v.exp_flags.zero = (v.exp_result == '0);
    return v;
  endfunction

  task automatic add_entry(input alu_cmd_e cmd, input word_t a, input word_t b);
    table_q.push_back(expect_entry(cmd, a, b));
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flags(input string name, input alu_flags_t got, input alu_flags_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  // One full four-phase transaction with req kept high for hold extra cycles
  task automatic run_entry(input vector_t v, input int hold);
    int edges;
    @(posedge clk);
    #1;
    request = '{cmd: v.cmd, a: v.a, b: v.b};
    req     = 1'b1;
    edges   = 0;
    do begin
      @(posedge clk);
      #1;
      edges++;
    end while (!ack);
    if (edges != 2) begin
      errors++;
      $display("ack rose %0d edges after req was raised instead of 2", edges);
    end
    check_word("response.result", response.result, v.exp_result);
    check_flags("response.flags", response.flags, v.exp_flags);
    repeat (hold) begin
      @(posedge clk);
      #1;
      if (!ack) begin
        errors++;
        $display("ack dropped while req was still high");
      end
      check_word("response.result", response.result, v.exp_result);
      check_flags("response.flags", response.flags, v.exp_flags);
    end
    req = 1'b0;
    @(posedge clk);
    #1;
    if (ack) begin
      errors++;
      $display("ack stayed high one edge after req dropped");
    end
  endtask

  initial begin
    reset   = 1'b1;
    req     = 1'b0;
    request = '0;

    add_entry(CMD_ADD,  32'h0000_0000, 32'h0000_0000);
    add_entry(CMD_ADD,  32'h0000_0001, 32'h0000_0002);
    add_entry(CMD_ADD,  32'h7FFF_FFFF, 32'h0000_0001);
    add_entry(CMD_ADD,  32'h8000_0000, 32'h8000_0000);
    add_entry(CMD_ADD,  32'hFFFF_FFFF, 32'h0000_0001);
    add_entry(CMD_SUB,  32'h0000_0005, 32'h0000_0005);
    add_entry(CMD_SUB,  32'h0000_0000, 32'h0000_0001);
    add_entry(CMD_SUB,  32'h8000_0000, 32'h0000_0001);
    add_entry(CMD_SUB,  32'h7FFF_FFFF, 32'hFFFF_FFFF);
    add_entry(CMD_SLT,  32'h0000_0001, 32'h0000_0002);
    add_entry(CMD_SLT,  32'h0000_0002, 32'h0000_0001);
    add_entry(CMD_SLT,  32'h8000_0000, 32'h0000_0001);
    add_entry(CMD_SLT,  32'h7FFF_FFFF, 32'h8000_0000);
    add_entry(CMD_SLT,  32'hFFFF_FFFF, 32'h0000_0000);
    add_entry(CMD_XOR,  32'hA5A5_A5A5, 32'hFFFF_FFFF);
    add_entry(CMD_XOR,  32'h1234_5678, 32'h1234_5678);
    add_entry(CMD_AND,  32'hFFFF_FFFF, 32'h0000_0000);
    add_entry(CMD_AND,  32'hF0F0_F0F0, 32'hFF00_FF00);
    add_entry(CMD_NAND, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    add_entry(CMD_NAND, 32'h0000_0000, 32'h0000_0000);
    add_entry(CMD_NOR,  32'h0000_0000, 32'h0000_0000);
    add_entry(CMD_NOR,  32'h8000_0000, 32'h7FFF_FFFF);
    add_entry(CMD_OR,   32'h0000_0000, 32'h0000_0000);
    add_entry(CMD_OR,   32'h1234_0000, 32'h0000_5678);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rng_state = lcg_next(rng_state);
      add_entry(alu_cmd_e'(rng_state[18:16]), random_word(), random_word());
    end

    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    // Idle state after reset with the zero flag set by the cleared word
    if (ack) begin
      errors++;
      $display("ack is high after reset with no request");
    end
    check_word("response.result", response.result, '0);
    check_flags("response.flags", response.flags, 3'b001);

    for (int i = 0; i < table_q.size(); i++) begin
      run_entry(table_q[i], i % 4);
    end

    $display("Check errors: %0d, assertion errors: %0d", errors,
             i_alu_unit.i_alu_unit_checker.assert_errors);
    if (errors == 0 && i_alu_unit.i_alu_unit_checker.assert_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    repeat (NUM_ENTRIES * 10 + 20) @(posedge clk);
    $display("Timeout: the transactions did not complete in the expected time");
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
hw/alu_cmd_pkg.sv
hw/alu_data_pkg.sv
hw/alu_decode.sv
hw/alu_execute.sv
hw/alu_result.sv
hw/alu_unit.sv
verif/alu_unit_checker.sv
verif/alu_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the ALU unit simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module alu_unit_tb -f build.f -o alu_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/alu_sim +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
